//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_nes_loader
FILELIST  = nes_loader_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- include/nes_loader_settings.svh
/*
 * NES cartridge loader constants
 * iNES header layout, page sizes, memory map and register width
 */
`ifndef NES_LOADER_SETTINGS_SVH
`define NES_LOADER_SETTINGS_SVH

// iNES header
`define NES_HDR_BYTES      16
`define NES_MAGIC_0        8'h4E  // "N"
`define NES_MAGIC_1        8'h45  // "E"
`define NES_MAGIC_2        8'h53  // "S"
`define NES_MAGIC_3        8'h1A  // MS-DOS EOF

// Page sizes as log2 of bytes
`define NES_PRG_PAGE_LOG2  14     // 16 KiB
`define NES_CHR_PAGE_LOG2  13     // 8 KiB

// Cartridge memory map
`define NES_ADDR_W         22
`define NES_PRG_BASE       22'h000000
`define NES_CHR_BASE       22'h200000

`define NES_CFG_ADR_W      2

`endif

//--- logic/ines_header_decode.sv
/*
 * iNES header store and decoder
 * Keeps the 16 header bytes, checks the magic and trainer bit,
 * and builds the mapper flags word when the last byte arrives
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module ines_header_decode (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          clear,
	input  logic                          hdr_wr,
	input  logic [3:0]                    hdr_index,
	input  nes_loader_pkg::byte_t         hdr_byte,
	input  logic                          invert_mirroring,
	output logic                          hdr_valid,
	output nes_loader_pkg::page_count_t   prg_pages,
	output nes_loader_pkg::page_count_t   chr_pages,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);

	localparam logic [3:0] HDR_LAST = 4'(`NES_HDR_BYTES - 1);

	nes_loader_pkg::byte_t hdr_mem [`NES_HDR_BYTES];
	nes_loader_pkg::byte_t hdr_view [`NES_HDR_BYTES];  // Store with the byte being written
	nes_loader_pkg::mapper_flags_t flags_next;
	nes_loader_pkg::mapper_flags_t flags_q;
	logic is_nes20;
	logic is_dirty;

	// Smallest c with pages <= 2^c, capped at 7
	function automatic nes_loader_pkg::size_code_t size_code(
		input nes_loader_pkg::page_count_t pages
	);
		nes_loader_pkg::size_code_t code;
		code = 3'd7;
		for (int c = 6; c >= 0; c--) begin
			if (pages <= (9'd1 << c))
				code = 3'(c);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < `NES_HDR_BYTES; i++)
				hdr_mem[i] <= '0;
		end else if (hdr_wr) begin
			hdr_mem[hdr_index] <= hdr_byte;
		end
	end

	always_comb begin
		for (int i = 0; i < `NES_HDR_BYTES; i++)
			hdr_view[i] = (hdr_wr && hdr_index == 4'(i)) ? hdr_byte : hdr_mem[i];
	end

	// Bytes 0 to 6 are already stored by the time the 16th byte arrives
	assign hdr_valid = hdr_mem[0] == `NES_MAGIC_0 && hdr_mem[1] == `NES_MAGIC_1 &&
		hdr_mem[2] == `NES_MAGIC_2 && hdr_mem[3] == `NES_MAGIC_3 &&
		!hdr_mem[6][2];  // Trainers not supported
	assign prg_pages = hdr_mem[4];
	assign chr_pages = hdr_mem[5];

	////////////////////////////////////////////////////////////
	// Flags word

	assign is_nes20 = hdr_view[7][3:2] == 2'b10;
	// Old dumps often carry junk in the padding bytes
	assign is_dirty = !is_nes20 && (hdr_view[9][7:1] != 7'd0 ||
		|{hdr_view[10], hdr_view[11], hdr_view[12], hdr_view[13], hdr_view[14], hdr_view[15]});

	assign flags_next = {
		6'd0,
		hdr_view[6][1],                        // Battery
		is_nes20 ? hdr_view[8] : 8'h00,        // NES 2.0 mapper extension
		hdr_view[6][3],                        // Four-screen
		hdr_view[5] == 8'd0,                   // CHR RAM
		hdr_view[6][0],                        // Raw mirroring bit
		size_code(hdr_view[5]),
		size_code(hdr_view[4]),
		is_dirty ? 4'h0 : hdr_view[7][7:4],
		hdr_view[6][7:4]
	};

	always_ff @(posedge clk) begin
		if (reset_nes)
			flags_q <= '0;
		else if (hdr_wr && hdr_index == HDR_LAST)
			flags_q <= flags_next;
	end

	// Mirroring follows the invert setting live
	assign mapper_flags = {flags_q[31:15], flags_q[14] ^ invert_mirroring, flags_q[13:0]};

endmodule

//--- logic/loader_cfg_regs.sv
/*
 * Loader configuration registers
 * Wishbone classic slave with the invert-mirroring control, status and mapper flags
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module loader_cfg_regs (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          cfg_cyc,
	input  logic                          cfg_stb,
	input  logic                          cfg_we,
	input  logic [`NES_CFG_ADR_W-1:0]     cfg_adr,
	input  logic [31:0]                   cfg_dat_w,
	output logic [31:0]                   cfg_dat_r,
	output logic                          cfg_ack,
	input  logic                          busy,
	input  logic                          done,
	input  logic                          error,
	input  nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          invert_mirroring
);

	localparam logic [`NES_CFG_ADR_W-1:0] ADR_CTRL   = 'd0;
	localparam logic [`NES_CFG_ADR_W-1:0] ADR_STATUS = 'd1;
	localparam logic [`NES_CFG_ADR_W-1:0] ADR_FLAGS  = 'd2;

	logic access;
	logic done_d;
	nes_loader_pkg::mapper_flags_t flags_q;

	// New access each time ack is low
	assign access = cfg_cyc && cfg_stb && !cfg_ack;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			cfg_ack          <= 1'b0;
			invert_mirroring <= 1'b0;
			done_d           <= 1'b0;
			flags_q          <= '0;
		end else begin
			cfg_ack <= access;
			done_d  <= done;
			if (access && cfg_we && cfg_adr == ADR_CTRL)
				invert_mirroring <= cfg_dat_w[0];  // Other addresses read only
			if (done && !done_d)
				flags_q <= mapper_flags;  // Snapshot at end of load
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (cfg_adr)
				ADR_CTRL:   cfg_dat_r <= {31'd0, invert_mirroring};
				ADR_STATUS: cfg_dat_r <= {29'd0, busy, done, error};
				ADR_FLAGS:  cfg_dat_r <= flags_q;
				default:    cfg_dat_r <= '0;
			endcase
		end
	end

endmodule

//--- logic/mem_write_stager.sv
/*
 * Memory write stager
 * One-deep holding register that runs a Wishbone classic write per byte
 * and holds the host off with dl_wait until the ack
 */
`timescale 1ns/1ps

module mem_write_stager (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      wr_req,
	input  nes_loader_pkg::mem_addr_t wr_addr,
	input  nes_loader_pkg::byte_t     wr_data,
	output logic                      dl_wait,
	output logic                      mem_cyc,
	output logic                      mem_stb,
	output logic                      mem_we,
	output nes_loader_pkg::mem_addr_t mem_adr,
	output nes_loader_pkg::byte_t     mem_dat_w,
	input  logic                      mem_ack
);

	logic pending;  // Write cycle open
	nes_loader_pkg::mem_addr_t adr_q;
	nes_loader_pkg::byte_t dat_q;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending <= 1'b0;
		end else begin
			if (pending && mem_ack)
				pending <= 1'b0;  // Cycle ends after the ack
			if (wr_req)
				pending <= 1'b1;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (wr_req) begin
			adr_q <= wr_addr;
			dat_q <= wr_data;
		end
	end

	assign mem_cyc   = pending;
	assign mem_stb   = pending;
	assign mem_we    = pending;
	assign mem_adr   = adr_q;
	assign mem_dat_w = dat_q;
	assign dl_wait   = pending;  // Back-pressure to the host

	// Wishbone classic, request held steady until ack
	a_hold_until_ack: assert property (@(posedge clk) disable iff (reset_nes)
		mem_stb && !mem_ack |=> mem_cyc && mem_stb && $stable(mem_adr) && $stable(mem_dat_w))
		else $error("memory request changed before ack");

endmodule

//--- logic/nes_loader_pkg.sv
/*
 * NES loader types
 * Vector typedefs for bytes, addresses, counts and flags, plus the loader FSM states
 */
`include "nes_loader_settings.svh"

package nes_loader_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`NES_ADDR_W-1:0] mem_addr_t;

	// Large enough for 255 PRG pages of 16 KiB
	typedef logic [`NES_ADDR_W-1:0] byte_count_t;

	typedef logic [7:0] page_count_t;  // Header bytes 4 and 5
	typedef logic [2:0] size_code_t;   // log2 of page count, capped at 7

	// Decoded cartridge flags as handed to the NES core
	typedef logic [31:0] mapper_flags_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		DONE,
		ERROR
	} loader_state_t;

endpackage

//--- logic/nes_loader_top.sv
/*
 * NES cartridge loader top
 * Connects the header decoder, loader FSM, write stager and register block
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module nes_loader_top (
	input  logic                      clk,
	input  logic                      reset_nes,
	// Host download port
	input  logic                      dl_active,
	input  logic                      dl_strobe,
	input  nes_loader_pkg::byte_t     dl_data,
	output logic                      dl_wait,
	// Cartridge memory, Wishbone master
	output logic                      mem_cyc,
	output logic                      mem_stb,
	output logic                      mem_we,
	output nes_loader_pkg::mem_addr_t mem_adr,
	output nes_loader_pkg::byte_t     mem_dat_w,
	input  logic                      mem_ack,
	// Configuration, Wishbone slave
	input  logic                      cfg_cyc,
	input  logic                      cfg_stb,
	input  logic                      cfg_we,
	input  logic [`NES_CFG_ADR_W-1:0] cfg_adr,
	input  logic [31:0]               cfg_dat_w,
	output logic [31:0]               cfg_dat_r,
	output logic                      cfg_ack,
	output logic                      done,
	output logic                      error
);

	logic hdr_wr;
	logic [3:0] hdr_index;
	logic hdr_valid;
	logic invert_mirroring;
	logic busy;
	logic wr_req;
	nes_loader_pkg::page_count_t prg_pages;
	nes_loader_pkg::page_count_t chr_pages;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	nes_loader_pkg::mem_addr_t wr_addr;
	nes_loader_pkg::byte_t wr_data;

	ines_header_decode hdr0 (
		.clk(clk), .reset_nes(reset_nes),
		.clear(1'b0),  // Every download rewrites all 16 bytes
		.hdr_wr(hdr_wr), .hdr_index(hdr_index), .hdr_byte(dl_data),
		.invert_mirroring(invert_mirroring), .hdr_valid(hdr_valid),
		.prg_pages(prg_pages), .chr_pages(chr_pages), .mapper_flags(mapper_flags)
	);

	rom_loader loader0 (
		.clk(clk), .reset_nes(reset_nes),
		.dl_active(dl_active), .dl_strobe(dl_strobe), .dl_data(dl_data), .dl_wait(dl_wait),
		.hdr_wr(hdr_wr), .hdr_index(hdr_index), .hdr_valid(hdr_valid),
		.prg_pages(prg_pages), .chr_pages(chr_pages),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.busy(busy), .done(done), .error(error)
	);

	mem_write_stager stager0 (
		.clk(clk), .reset_nes(reset_nes),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .dl_wait(dl_wait),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
		.mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_ack(mem_ack)
	);

	loader_cfg_regs regs0 (
		.clk(clk), .reset_nes(reset_nes),
		.cfg_cyc(cfg_cyc), .cfg_stb(cfg_stb), .cfg_we(cfg_we), .cfg_adr(cfg_adr),
		.cfg_dat_w(cfg_dat_w), .cfg_dat_r(cfg_dat_r), .cfg_ack(cfg_ack),
		.busy(busy), .done(done), .error(error), .mapper_flags(mapper_flags),
		.invert_mirroring(invert_mirroring)
	);

endmodule

//--- logic/rom_loader.sv
/*
 * ROM loader FSM
 * Counts the header bytes, then turns PRG and CHR bytes into memory write requests
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module rom_loader (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        dl_active,
	input  logic                        dl_strobe,
	input  nes_loader_pkg::byte_t       dl_data,
	input  logic                        dl_wait,
	output logic                        hdr_wr,
	output logic [3:0]                  hdr_index,
	input  logic                        hdr_valid,
	input  nes_loader_pkg::page_count_t prg_pages,
	input  nes_loader_pkg::page_count_t chr_pages,
	output logic                        wr_req,
	output nes_loader_pkg::mem_addr_t   wr_addr,
	output nes_loader_pkg::byte_t       wr_data,
	output logic                        busy,
	output logic                        done,
	output logic                        error
);

	localparam logic [3:0] HDR_LAST = 4'(`NES_HDR_BYTES - 1);

	nes_loader_pkg::loader_state_t state;
	nes_loader_pkg::loader_state_t after_prg;  // CHR phase or straight to DONE
	nes_loader_pkg::byte_count_t bytes_left;
	nes_loader_pkg::byte_count_t prg_bytes;
	nes_loader_pkg::byte_count_t chr_bytes;
	logic [3:0] hdr_ctr;
	logic dl_active_d;
	logic restart;
	logic byte_in;
	logic in_payload;

	assign restart = dl_active && !dl_active_d;
	assign byte_in = dl_strobe && dl_active;
	assign in_payload = state == nes_loader_pkg::LOAD_PRG || state == nes_loader_pkg::LOAD_CHR;

	assign prg_bytes = nes_loader_pkg::byte_count_t'(prg_pages) << `NES_PRG_PAGE_LOG2;
	assign chr_bytes = nes_loader_pkg::byte_count_t'(chr_pages) << `NES_CHR_PAGE_LOG2;
	assign after_prg = (chr_pages != 8'd0) ? nes_loader_pkg::LOAD_CHR : nes_loader_pkg::DONE;

	// A strobe in the restart cycle is header byte 0
	assign hdr_wr    = byte_in && (restart || state == nes_loader_pkg::LOAD_HEADER);
	assign hdr_index = restart ? 4'd0 : hdr_ctr;

	assign wr_req  = byte_in && !restart && in_payload;
	assign wr_data = dl_data;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state       <= nes_loader_pkg::LOAD_HEADER;
			hdr_ctr     <= 4'd0;
			bytes_left  <= '0;
			wr_addr     <= '0;
			dl_active_d <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (restart) begin
				state   <= nes_loader_pkg::LOAD_HEADER;
				hdr_ctr <= byte_in ? 4'd1 : 4'd0;
			end else begin
				case (state)
					nes_loader_pkg::LOAD_HEADER: begin
						if (byte_in) begin
							hdr_ctr <= hdr_ctr + 4'd1;  // Wraps to 0 after the last byte
							if (hdr_ctr == HDR_LAST) begin
								if (!hdr_valid) begin
									state <= nes_loader_pkg::ERROR;
								end else if (prg_pages != 8'd0) begin
									state      <= nes_loader_pkg::LOAD_PRG;
									bytes_left <= prg_bytes;
									wr_addr    <= `NES_PRG_BASE;
								end else begin
									state      <= after_prg;  // Empty PRG phase skipped
									bytes_left <= chr_bytes;
									wr_addr    <= `NES_CHR_BASE;
								end
							end
						end
					end
					nes_loader_pkg::LOAD_PRG: begin
						if (byte_in) begin
							if (bytes_left == 22'd1) begin
								state      <= after_prg;
								bytes_left <= chr_bytes;
								wr_addr    <= `NES_CHR_BASE;
							end else begin
								bytes_left <= bytes_left - 22'd1;
								wr_addr    <= wr_addr + 22'd1;
							end
						end
					end
					nes_loader_pkg::LOAD_CHR: begin
						if (byte_in) begin
							if (bytes_left == 22'd1) begin
								state <= nes_loader_pkg::DONE;
							end else begin
								bytes_left <= bytes_left - 22'd1;
								wr_addr    <= wr_addr + 22'd1;
							end
						end
					end
					default: ;  // DONE and ERROR hold until the next restart
				endcase
			end
		end
	end

	// done waits for the last write to be acknowledged
	assign done  = (state == nes_loader_pkg::DONE && !dl_wait) || state == nes_loader_pkg::ERROR;
	assign error = state == nes_loader_pkg::ERROR;
	assign busy  = in_payload || (state == nes_loader_pkg::DONE && dl_wait);

	// Host side of the handshake, dl_wait comes from the write stager
	a_no_strobe_in_wait: assert property (@(posedge clk) disable iff (reset_nes)
		dl_wait |-> !dl_strobe)
		else $error("download strobe while dl_wait is high");

endmodule

//--- nes_loader_top.f
+incdir+include
logic/nes_loader_pkg.sv
logic/ines_header_decode.sv
logic/rom_loader.sv
logic/mem_write_stager.sv
logic/loader_cfg_regs.sv
logic/nes_loader_top.sv
verification/loader_checker.sv
verification/tb_nes_loader.sv

//--- verification/loader_checker.sv
/*
 * Loader checker
 * Compares memory writes and end-of-load status against the expected values
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module loader_checker (
	input logic                   clk,
	input logic                   reset_nes,
	input logic                   dl_strobe,
	input logic                   dl_wait,
	input logic                   mem_cyc,
	input logic                   mem_stb,
	input logic                   mem_we,
	input logic [`NES_ADDR_W-1:0] mem_adr,
	input logic [7:0]             mem_dat_w,
	input logic                   mem_ack,
	input logic                   error
);

	logic [`NES_ADDR_W-1:0] exp_adr[$];
	logic [7:0] exp_dat[$];
	logic [`NES_ADDR_W-1:0] a;
	logic [7:0] d;
	int error_count = 0;
	int test_errors = 0;
	int test_count = 0;
	int write_count = 0;
	int test_writes = 0;

	task automatic note_error();
		error_count++;
		test_errors++;
	endtask

	task automatic expect_write(input logic [`NES_ADDR_W-1:0] adr, input logic [7:0] dat);
		exp_adr.push_back(adr);
		exp_dat.push_back(dat);
	endtask

	task automatic start_test();
		test_errors = 0;
		test_writes = 0;
	endtask

	// Accepted write is stb with ack
	always @(posedge clk) begin
		if (!reset_nes) begin
			if (dl_strobe && (dl_wait || mem_cyc)) begin
				$display("Host strobed at %0t while a memory write was in flight", $time);
				note_error();
			end
			if (mem_stb && mem_ack) begin
				if (!mem_cyc || !mem_we) begin
					$display("Write at %0t without cyc or we", $time);
					note_error();
				end
				if (exp_adr.size() == 0) begin
					$display("Unexpected memory write at %0t to address %h", $time, mem_adr);
					note_error();
				end else begin
					a = exp_adr.pop_front();
					d = exp_dat.pop_front();
					if (mem_adr !== a || mem_dat_w !== d) begin
						$display("Mismatch at %0t: write %h to %h, expected %h to %h",
							$time, mem_dat_w, mem_adr, d, a);
						note_error();
					end
					write_count++;
					test_writes++;
				end
			end
		end
	end

	task automatic finish_test(input int t, input logic exp_error, input logic [31:0] exp_flags,
			input logic got_done, input logic got_error, input logic [31:0] got_flags);
		if (exp_adr.size() != 0) begin
			$display("Test %0d lost %0d payload writes", t, exp_adr.size());
			note_error();
			exp_adr.delete();
			exp_dat.delete();
		end
		if (got_done !== 1'b1) begin
			$display("Mismatch at %0t: test %0d status done is %b", $time, t, got_done);
			note_error();
		end
		if (got_error !== exp_error) begin
			$display("Mismatch at %0t: test %0d error is %b, expected %b",
				$time, t, got_error, exp_error);
			note_error();
		end
		if (error !== exp_error) begin
			$display("Mismatch at %0t: test %0d error output is %b, expected %b",
				$time, t, error, exp_error);
			note_error();
		end
		if (!exp_error && got_flags !== exp_flags) begin
			$display("Mismatch at %0t: test %0d flags %h, expected %h",
				$time, t, got_flags, exp_flags);
			note_error();
		end
		test_count++;
		$display("Test %0d %s, %0d writes checked", t, (test_errors == 0) ? "ok" : "failed",
			test_writes);
	endtask

	task automatic report_totals();
		$display("Tests %0d, writes %0d, errors %0d", test_count, write_count, error_count);
	endtask

endmodule

//--- verification/nes_loader_testdata.txt
# Header bytes 0 to 15, invert mirroring, expected error, expected mapper flags (all hex)
# Flags are only compared when no error is expected
4E 45 53 1A 01 01 10 00 00 00 00 00 00 00 00 00 0 0 00000001
4E 45 53 1A 01 01 10 00 00 00 00 00 00 00 00 00 1 0 00004001
4E 45 53 1A 02 00 23 40 00 00 00 00 00 00 00 00 0 0 0200C142
4E 45 53 1A 02 00 23 40 00 00 00 00 00 00 00 00 1 0 02008142
4E 45 53 1A 01 01 18 30 00 00 00 00 55 00 00 00 0 0 00010001
4E 45 53 1A 01 02 00 58 03 00 07 00 00 00 00 00 0 0 00060850
4D 45 53 1A 01 01 00 00 00 00 00 00 00 00 00 00 0 1 00000000
4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 0 1 00000000
4E 45 53 1A 00 01 00 00 00 00 00 00 00 00 00 00 1 0 00004000
4E 45 53 1A 03 00 00 00 00 00 00 00 00 00 00 00 0 0 00008200
4E 45 53 1A 01 01 70 A0 00 02 00 00 00 00 00 00 0 0 00000007

//--- verification/tb_nes_loader.sv
/*
 * NES loader testbench
 * Reads headers from the test data file, downloads LFSR payloads and models the memory
 */
`timescale 1ns/1ps
`include "nes_loader_settings.svh"

module tb_nes_loader;

	localparam int MAX_TESTS = 16;

	logic clk;
	logic reset_nes;
	logic dl_active;
	logic dl_strobe;
	logic [7:0] dl_data;
	logic dl_wait;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [`NES_ADDR_W-1:0] mem_adr;
	logic [7:0] mem_dat_w;
	logic mem_ack;
	logic cfg_cyc;
	logic cfg_stb;
	logic cfg_we;
	logic [`NES_CFG_ADR_W-1:0] cfg_adr;
	logic [31:0] cfg_dat_w;
	logic [31:0] cfg_dat_r;
	logic cfg_ack;
	logic done;
	logic error;

	logic [7:0] hdr_tab [MAX_TESTS][`NES_HDR_BYTES];
	logic inv_tab [MAX_TESTS];
	logic err_tab [MAX_TESTS];
	logic [31:0] flags_tab [MAX_TESTS];
	int num_tests;
	int limit;
	int cycles;
	logic [31:0] lfsr;
	int unsigned delay_q[$];  // One ack delay per payload write

	nes_loader_top dut0 (.*);

	loader_checker chk0 (
		.clk(clk), .reset_nes(reset_nes), .dl_strobe(dl_strobe), .dl_wait(dl_wait),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w), .mem_ack(mem_ack), .error(error)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Random source

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = 8'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);  // One step per bit
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Host side

	task automatic send_byte(input logic [7:0] b);
		while (dl_wait)
			@(negedge clk);
		dl_strobe = 1'b1;
		dl_data   = b;
		@(negedge clk);
		dl_strobe = 1'b0;
	endtask

	task automatic send_payload_byte(input logic [`NES_ADDR_W-1:0] addr);
		logic [7:0] b;
		b = take_bits(8);
		delay_q.push_back(int'(take_bits(2)));
		chk0.expect_write(addr, b);
		send_byte(b);
	endtask

	task automatic cfg_access(input logic we, input logic [`NES_CFG_ADR_W-1:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		cfg_cyc   = 1'b1;
		cfg_stb   = 1'b1;
		cfg_we    = we;
		cfg_adr   = adr;
		cfg_dat_w = wdat;
		@(negedge clk);
		while (!cfg_ack)
			@(negedge clk);
		rdat    = cfg_dat_r;
		cfg_cyc = 1'b0;
		cfg_stb = 1'b0;
		cfg_we  = 1'b0;
	endtask

	task automatic run_test(input int t);
		logic [31:0] rd;
		logic [31:0] status;
		logic [31:0] flags;
		int prg_n;
		int chr_n;
		cfg_access(1'b1, 'd0, {31'd0, inv_tab[t]}, rd);
		dl_active = 1'b0;
		@(negedge clk);
		dl_active = 1'b1;  // Rising edge restarts the loader
		@(negedge clk);
		chk0.start_test();
		for (int i = 0; i < `NES_HDR_BYTES; i++)
			send_byte(hdr_tab[t][i]);
		if (!err_tab[t]) begin
			prg_n = int'(hdr_tab[t][4]) << `NES_PRG_PAGE_LOG2;
			chr_n = int'(hdr_tab[t][5]) << `NES_CHR_PAGE_LOG2;
			for (int i = 0; i < prg_n; i++)
				send_payload_byte(`NES_PRG_BASE + (`NES_ADDR_W)'(i));
			for (int i = 0; i < chr_n; i++)
				send_payload_byte(`NES_CHR_BASE + (`NES_ADDR_W)'(i));
		end
		while (!done)
			@(negedge clk);
		cfg_access(1'b0, 'd1, 32'd0, status);
		cfg_access(1'b0, 'd2, 32'd0, flags);
		dl_active = 1'b0;
		chk0.finish_test(t, err_tab[t], flags_tab[t], status[1], status[0], flags);
	endtask

	// Each data line holds 16 header bytes, invert, expected error and expected flags
	task automatic load_tests();
		int fd;
		int n;
		string line;
		logic [7:0] hb [`NES_HDR_BYTES];
		logic [3:0] inv;
		logic [3:0] err;
		logic [31:0] flg;
		num_tests = 0;
		fd = $fopen("verification/nes_loader_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
			return;
		end
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			n = $fgets(line, fd);
			if (n == 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				hb[0], hb[1], hb[2], hb[3], hb[4], hb[5], hb[6], hb[7],
				hb[8], hb[9], hb[10], hb[11], hb[12], hb[13], hb[14], hb[15],
				inv, err, flg);
			if (n != 19)
				continue;
			for (int i = 0; i < `NES_HDR_BYTES; i++)
				hdr_tab[num_tests][i] = hb[i];
			inv_tab[num_tests]   = inv[0];
			err_tab[num_tests]   = err[0];
			flags_tab[num_tests] = flg;
			num_tests++;
		end
		$fclose(fd);
	endtask

	// Memory model acks after a random delay
	initial begin
		int unsigned d;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (mem_stb) begin
				d = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
				repeat (d) @(negedge clk);
				mem_ack = 1'b1;
				@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, DUT did not finish", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		int payload;
		reset_nes = 1'b1;
		dl_active = 1'b0;
		dl_strobe = 1'b0;
		dl_data   = 8'd0;
		cfg_cyc   = 1'b0;
		cfg_stb   = 1'b0;
		cfg_we    = 1'b0;
		cfg_adr   = '0;
		cfg_dat_w = 32'd0;
		cycles    = 0;
		limit     = 2000;
		lfsr      = 32'h2ae6;
		load_tests();
		for (int t = 0; t < num_tests; t++) begin
			payload = err_tab[t] ? 0 : (int'(hdr_tab[t][4]) << `NES_PRG_PAGE_LOG2) +
				(int'(hdr_tab[t][5]) << `NES_CHR_PAGE_LOG2);
			limit += (`NES_HDR_BYTES + payload) * 8 + 100;
		end
		repeat (4) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		@(negedge clk);
		chk0.report_totals();
		if (chk0.error_count == 0 && num_tests > 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
